// ==== common/afu_macros.svh ====
/*
 * Widths and soft-reset timing for the job-completion path.
 * Include before any code that sizes ports or counters.
 */

`ifndef AFU_MACROS_SVH
`define AFU_MACROS_SVH

// Done word seen by the host, item count over checksum
`define AFU_WORD_W 64

// Response data and checksum width
`define AFU_DATA_W 32

// Each statistics counter
`define AFU_STAT_W 16

// Cycles soft_rstn is held low per soft reset
`define AFU_SOFT_RESET_CYCLES 4

`endif

// ==== common/afu_pkg.sv ====
/*
 * Shared types of the job-completion path: memory responses,
 * compute-unit result, response statistics and the done FSM states.
 * Modules import it inside their body and name types by scope in ports.
 */

`default_nettype none

`include "afu_macros.svh"

package afu_pkg;

	////////////////////////////////////////////////////////////
	// Memory responses
	////////////////////////////////////////////////////////////

	// Kind of a memory response, 2 bits
	typedef enum logic [1:0] {
		READ_OK    = 2'd0,
		WRITE_OK   = 2'd1,
		RESP_ERROR = 2'd2
	} resp_kind_t;

	// One response from the memory side, 34 bits
	typedef struct packed {
		resp_kind_t             kind;
		logic [`AFU_DATA_W-1:0] data;
	} mem_resp_t;

	////////////////////////////////////////////////////////////
	// Job result and statistics
	////////////////////////////////////////////////////////////

	// Result of one job, also the done word
	// Item count sits in the upper half
	typedef struct packed {
		logic [`AFU_WORD_W-`AFU_DATA_W-1:0] item_count;
		logic [`AFU_DATA_W-1:0]             checksum;
	} cu_return_t;

	// Accepted responses by kind, 48 bits
	typedef struct packed {
		logic [`AFU_STAT_W-1:0] read_count;
		logic [`AFU_STAT_W-1:0] write_count;
		logic [`AFU_STAT_W-1:0] error_count;
	} response_stats_t;

	////////////////////////////////////////////////////////////
	// Done controller
	////////////////////////////////////////////////////////////

	// Completion FSM states
	typedef enum logic [2:0] {
		DONE_RESET         = 3'd0,
		DONE_IDLE          = 3'd1,
		DONE_RESET_REQ     = 3'd2,
		DONE_RESET_PENDING = 3'd3,
		DONE_REPORT_REQ    = 3'd4,
		DONE_ACK_WAIT      = 3'd5
	} done_state_t;

endpackage

`default_nettype wire

// ==== rtl/done_control/soft_reset_sequencer.sv ====
/*
 * Stretches the one-cycle low reset request from the done controller
 * into a soft_rstn pulse of a fixed number of cycles.
 */

`default_nettype none

`include "afu_macros.svh"

module soft_reset_sequencer (
	input  logic clock,
	input  logic rstn,
	input  logic reset_done,
	output logic soft_rstn
);
	localparam int CNT_W = $clog2(`AFU_SOFT_RESET_CYCLES + 1);

	logic             reset_done_q;
	logic             start;
	logic [CNT_W-1:0] count;

	// Falling edge of the request
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			reset_done_q <= 1'b1;
		end else begin
			reset_done_q <= reset_done;
		end
	end

	// Requests during a running pulse are dropped
	assign start = reset_done_q & ~reset_done & soft_rstn;

	////////////////////////////////////////////////////////////
	// Pulse counter
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			soft_rstn <= 1'b1;
			count     <= '0;
		end else if (start) begin
			soft_rstn <= 1'b0;
			count     <= CNT_W'(`AFU_SOFT_RESET_CYCLES - 1);
		end else if (!soft_rstn) begin
			// Release on the last counted cycle
			if (count == '0)
				soft_rstn <= 1'b1;
			else
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/done_control/done_control.sv ====
/*
 * Completion FSM of the accelerator. Latches the job result and the
 * statistics, requests a soft reset, waits for it to finish and then
 * offers the report to the host over a four-phase req/ack port.
 */

`default_nettype none

module done_control (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     soft_rstn,
	input  logic                     enabled_in,
	input  afu_pkg::cu_return_t      cu_return,
	input  afu_pkg::response_stats_t response_statistics,
	input  logic                     cu_done,
	input  logic                     done_ack,
	output logic                     reset_done,
	output logic                     done_req,
	output afu_pkg::cu_return_t      done_word,
	output afu_pkg::response_stats_t done_stats
);
	import afu_pkg::*;

	done_state_t     current_state;
	done_state_t     next_state;
	logic            enabled;
	logic [1:0]      soft_rstn_sync;
	logic            soft_rstn_prev;
	logic            soft_rstn_rise;
	logic            soft_reset_seen;
	logic            start_reset;
	logic            start_report;
	logic            end_report;
	cu_return_t      word_latched;
	response_stats_t stats_latched;

	////////////////////////////////////////////////////////////
	// Soft reset completion
	////////////////////////////////////////////////////////////

	// Two-stage sync, idle value is high
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			soft_rstn_sync <= 2'b11;
			soft_rstn_prev <= 1'b1;
		end else begin
			soft_rstn_sync <= {soft_rstn_sync[0], soft_rstn};
			soft_rstn_prev <= soft_rstn_sync[1];
		end
	end

	assign soft_rstn_rise = soft_rstn_sync[1] & ~soft_rstn_prev;

	// Sticky, so a rise during a disabled stretch is not lost
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			soft_reset_seen <= 1'b0;
		end else if (start_reset) begin
			soft_reset_seen <= 1'b0;
		end else if (soft_rstn_rise) begin
			soft_reset_seen <= 1'b1;
		end
	end

	// Registered enable
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enabled_in;
		end
	end

	////////////////////////////////////////////////////////////
	// State machine
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			current_state <= DONE_RESET;
		end else if (enabled) begin
			current_state <= next_state;
		end
	end

	always_comb begin
		next_state = current_state;
		case (current_state)
			DONE_RESET: next_state = DONE_IDLE;
			// cu_done is a level, a job finished earlier waits here
			DONE_IDLE: begin
				if (cu_done)
					next_state = DONE_RESET_REQ;
			end
			DONE_RESET_REQ: next_state = DONE_RESET_PENDING;
			DONE_RESET_PENDING: begin
				if (soft_reset_seen || soft_rstn_rise)
					next_state = DONE_REPORT_REQ;
			end
			DONE_REPORT_REQ: begin
				if (done_ack)
					next_state = DONE_ACK_WAIT;
			end
			// Four-phase, wait for ack to drop
			DONE_ACK_WAIT: begin
				if (!done_ack)
					next_state = DONE_IDLE;
			end
			default: next_state = DONE_RESET;
		endcase
	end

	// Transition strobes, only while enabled
	assign start_reset  = enabled && (current_state == DONE_IDLE) && cu_done;
	assign start_report = enabled && (current_state == DONE_RESET_PENDING) &&
		(next_state == DONE_REPORT_REQ);
	assign end_report   = enabled && (current_state == DONE_REPORT_REQ) && done_ack;

	////////////////////////////////////////////////////////////
	// Report latch and outputs
	////////////////////////////////////////////////////////////

	// Tracks the result while idle, frozen once the job is taken
	always_ff @(posedge clock) begin
		if (current_state == DONE_IDLE) begin
			word_latched  <= cu_return;
			stats_latched <= response_statistics;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			reset_done <= 1'b1;
			done_req   <= 1'b0;
			done_word  <= '0;
			done_stats <= '0;
		end else begin
			// One-cycle low pulse, lines up with DONE_RESET_REQ
			reset_done <= ~start_reset;
			if (start_report) begin
				done_req   <= 1'b1;
				done_word  <= word_latched;
				done_stats <= stats_latched;
			end else if (end_report) begin
				done_req   <= 1'b0;
				done_word  <= '0;
				done_stats <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/compute_unit.sv ====
/*
 * Job engine. Takes memory responses over a four-phase req/ack port,
 * counts them toward job_size, sums non-error data into a checksum and
 * raises cu_done. Cleared by soft reset before the next job.
 */

`default_nettype none

`include "afu_macros.svh"

module compute_unit (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   soft_rstn,
	input  logic [`AFU_DATA_W-1:0] job_size,
	input  logic                   resp_req,
	input  afu_pkg::mem_resp_t     resp,
	output logic                   resp_ack,
	output logic                   accept_valid,
	output afu_pkg::mem_resp_t     accept_resp,
	output afu_pkg::cu_return_t    cu_return,
	output logic                   cu_done
);
	import afu_pkg::*;

	logic [`AFU_DATA_W-1:0] item_count_next;

	////////////////////////////////////////////////////////////
	// Response handshake
	////////////////////////////////////////////////////////////

	// New request seen, job still open and not being cleared
	assign accept_valid = resp_req & ~resp_ack & ~cu_done & soft_rstn;
	assign accept_resp  = resp;

	// Ack follows req one cycle later in both directions
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			resp_ack <= 1'b0;
		end else if (accept_valid) begin
			resp_ack <= 1'b1;
		end else if (!resp_req) begin
			resp_ack <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Count and checksum
	////////////////////////////////////////////////////////////

	assign item_count_next = cu_return.item_count + 1'b1;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_return <= '0;
			cu_done   <= 1'b0;
		end else if (!soft_rstn) begin
			cu_return <= '0;
			cu_done   <= 1'b0;
		end else if (accept_valid) begin
			cu_return.item_count <= item_count_next;
			// Error data stays out of the sum, wraps mod 2^32
			if (resp.kind != RESP_ERROR)
				cu_return.checksum <= cu_return.checksum + resp.data;
			// Level, held until soft reset
			if (item_count_next == job_size)
				cu_done <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/response_stats.sv ====
/*
 * Per-kind counters of accepted memory responses. Counters saturate
 * and are cleared by soft reset between jobs.
 */

`default_nettype none

`include "afu_macros.svh"

module response_stats (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     soft_rstn,
	input  logic                     accept_valid,
	input  afu_pkg::mem_resp_t       accept_resp,
	output afu_pkg::response_stats_t stats
);
	import afu_pkg::*;

	logic [`AFU_STAT_W-1:0] read_next;
	logic [`AFU_STAT_W-1:0] write_next;
	logic [`AFU_STAT_W-1:0] error_next;

	// Increment that holds at all ones
	function automatic logic [`AFU_STAT_W-1:0] sat_inc(input logic [`AFU_STAT_W-1:0] count);
		return (count == '1) ? count : count + 1'b1;
	endfunction

	assign read_next  = sat_inc(stats.read_count);
	assign write_next = sat_inc(stats.write_count);
	assign error_next = sat_inc(stats.error_count);

	////////////////////////////////////////////////////////////
	// Counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			stats <= '0;
		end else if (!soft_rstn) begin
			stats <= '0;
		end else if (accept_valid) begin
			case (accept_resp.kind)
				READ_OK:    stats.read_count  <= read_next;
				WRITE_OK:   stats.write_count <= write_next;
				RESP_ERROR: stats.error_count <= error_next;
				// Unused encoding is not counted
				default: begin
					stats <= stats;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/afu_done_top.sv ====
/*
 * Top of the job-completion path. Memory responses come in on one
 * four-phase port, the job report leaves on another. Soft reset
 * stays internal.
 */

`default_nettype none

`include "afu_macros.svh"

module afu_done_top (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     enabled_in,
	input  logic [`AFU_DATA_W-1:0]   job_size,
	input  logic                     resp_req,
	input  afu_pkg::mem_resp_t       resp,
	input  logic                     done_ack,
	output logic                     resp_ack,
	output logic                     done_req,
	output afu_pkg::cu_return_t      done_word,
	output afu_pkg::response_stats_t done_stats
);
	import afu_pkg::*;

	logic            accept_valid;
	mem_resp_t       accept_resp;
	cu_return_t      cu_return;
	logic            cu_done;
	response_stats_t stats;
	logic            reset_done;
	logic            soft_rstn;

	////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////

	compute_unit u_compute_unit (
		.clock        (clock),
		.rstn         (rstn),
		.soft_rstn    (soft_rstn),
		.job_size     (job_size),
		.resp_req     (resp_req),
		.resp         (resp),
		.resp_ack     (resp_ack),
		.accept_valid (accept_valid),
		.accept_resp  (accept_resp),
		.cu_return    (cu_return),
		.cu_done      (cu_done)
	);

	response_stats u_response_stats (
		.clock        (clock),
		.rstn         (rstn),
		.soft_rstn    (soft_rstn),
		.accept_valid (accept_valid),
		.accept_resp  (accept_resp),
		.stats        (stats)
	);

	////////////////////////////////////////////////////////////
	// Completion and soft reset
	////////////////////////////////////////////////////////////

	done_control u_done_control (
		.clock               (clock),
		.rstn                (rstn),
		.soft_rstn           (soft_rstn),
		.enabled_in          (enabled_in),
		.cu_return           (cu_return),
		.response_statistics (stats),
		.cu_done             (cu_done),
		.done_ack            (done_ack),
		.reset_done          (reset_done),
		.done_req            (done_req),
		.done_word           (done_word),
		.done_stats          (done_stats)
	);

	soft_reset_sequencer u_soft_reset_sequencer (
		.clock      (clock),
		.rstn       (rstn),
		.reset_done (reset_done),
		.soft_rstn  (soft_rstn)
	);

endmodule

`default_nettype wire

// ==== verification/afu_done_tb.sv ====
/*
 * Directed testbench for the job-completion path. Plays the memory side
 * and the host side over their four-phase ports and checks each report
 * against counts and checksums worked out from the stimulus.
 */

`default_nettype none

`include "afu_macros.svh"

module afu_done_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import afu_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int HANDSHAKE_LIMIT = 64;
	localparam int REPORT_LIMIT = 100;
	localparam int MAX_HOLD = 20;
	localparam int QUIET_CYCLES = 20;

	// Job sizes per test
	localparam int JOB_MIXED = 12;
	localparam int JOB_HOLD_A = 6;
	localparam int JOB_HOLD_B = 5;
	localparam int JOB_PAIR_A = 9;
	localparam int JOB_PAIR_B = 7;
	localparam int JOB_DISABLED = 8;
	localparam int JOB_ERRORS = 10;

	// Run length bound from responses, reports and quiet stretches
	localparam int TOTAL_RESPONSES = JOB_MIXED + JOB_HOLD_A + JOB_HOLD_B + JOB_PAIR_A +
		JOB_PAIR_B + JOB_DISABLED + JOB_ERRORS;
	localparam int TOTAL_REPORTS = 7;
	localparam int WATCHDOG_CYCLES = TOTAL_RESPONSES * 8 +
		TOTAL_REPORTS * (40 + MAX_HOLD) + 2 * QUIET_CYCLES + 100;

	logic                   clock;
	logic                   rstn;
	logic                   enabled_in;
	logic [`AFU_DATA_W-1:0] job_size;
	logic                   resp_req;
	mem_resp_t              resp;
	logic                   done_ack;
	logic                   resp_ack;
	logic                   done_req;
	cu_return_t             done_word;
	response_stats_t        done_stats;
	logic [31:0]            lcg_state;

	afu_done_top DUT (
		.clock      (clock),
		.rstn       (rstn),
		.enabled_in (enabled_in),
		.job_size   (job_size),
		.resp_req   (resp_req),
		.resp       (resp),
		.done_ack   (done_ack),
		.resp_ack   (resp_ack),
		.done_req   (done_req),
		.done_word  (done_word),
		.done_stats (done_stats)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	////////////////////////////////////////////////////////////
	// Helpers and compare tasks
	////////////////////////////////////////////////////////////

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "Run stopped on error");
	endtask

	// Numerical Recipes constants
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_word(input string name, input cu_return_t exp, input cu_return_t act);
		if (exp !== act) begin
			$display("Mismatch in %s: expected count %0d checksum %h, actual count %0d checksum %h",
				name, exp.item_count, exp.checksum, act.item_count, act.checksum);
			report_failure({name, ": done word differs"});
		end
	endtask

	task automatic check_stats(input string name, input response_stats_t exp,
			input response_stats_t act);
		if (exp !== act) begin
			$display("Mismatch in %s: expected r/w/e %0d/%0d/%0d, actual r/w/e %0d/%0d/%0d",
				name, exp.read_count, exp.write_count, exp.error_count,
				act.read_count, act.write_count, act.error_count);
			report_failure({name, ": statistics differ"});
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("Mismatch in %s: expected %b, actual %b", name, exp, act);
			report_failure({name, ": control flag differs"});
		end
	endtask

	////////////////////////////////////////////////////////////
	// Memory side and host side
	////////////////////////////////////////////////////////////

	// One four-phase response, ack sampled on the falling edge
	task automatic send_response(input string name, input mem_resp_t value);
		int waited;
		waited = 0;
		@(posedge clock);
		resp     <= value;
		resp_req <= 1'b1;
		do begin
			@(negedge clock);
			waited++;
			if (waited > HANDSHAKE_LIMIT)
				report_failure({name, ": resp_ack never rose"});
		end while (!resp_ack);
		@(posedge clock);
		resp_req <= 1'b0;
		waited = 0;
		do begin
			@(negedge clock);
			waited++;
			if (waited > HANDSHAKE_LIMIT)
				report_failure({name, ": resp_ack never fell"});
		end while (resp_ack);
	endtask

	// Whole job, expected report built from the kinds and data sent
	task automatic send_job(input string name, input int size, input bit all_errors,
			output cu_return_t exp_word, output response_stats_t exp_stats);
		mem_resp_t   item;
		logic [31:0] sel;
		exp_word  = '0;
		exp_stats = '0;
		@(posedge clock);
		job_size <= size;
		for (int i = 0; i < size; i++) begin
			sel = lcg_next();
			item.data = lcg_next();
			if (all_errors)
				item.kind = RESP_ERROR;
			else if ((sel >> 16) % 3 == 0)
				item.kind = READ_OK;
			else if ((sel >> 16) % 3 == 1)
				item.kind = WRITE_OK;
			else
				item.kind = RESP_ERROR;
			exp_word.item_count++;
			case (item.kind)
				READ_OK:  exp_stats.read_count++;
				WRITE_OK: exp_stats.write_count++;
				default:  exp_stats.error_count++;
			endcase
			// Error data never enters the sum
			if (item.kind != RESP_ERROR)
				exp_word.checksum = exp_word.checksum + item.data;
			send_response(name, item);
		end
	endtask

	// Wait for the report, hold ack back, then complete the handshake
	task automatic receive_report(input string name, input cu_return_t exp_word,
			input response_stats_t exp_stats, input int hold_cycles, input bit keep_ack);
		int waited;
		waited = 0;
		do begin
			@(negedge clock);
			waited++;
			if (waited > REPORT_LIMIT)
				report_failure({name, ": done_req never rose"});
		end while (!done_req);
		check_word(name, exp_word, done_word);
		check_stats(name, exp_stats, done_stats);
		// Report must sit still while ack is withheld
		repeat (hold_cycles) begin
			@(negedge clock);
			check_flag({name, " hold"}, 1'b1, done_req);
			check_word({name, " hold"}, exp_word, done_word);
			check_stats({name, " hold"}, exp_stats, done_stats);
		end
		@(posedge clock);
		done_ack <= 1'b1;
		waited = 0;
		do begin
			@(negedge clock);
			waited++;
			if (waited > HANDSHAKE_LIMIT)
				report_failure({name, ": done_req stayed high after done_ack"});
		end while (done_req);
		check_word({name, " cleared"}, '0, done_word);
		check_stats({name, " cleared"}, '0, done_stats);
		if (!keep_ack) begin
			@(posedge clock);
			done_ack <= 1'b0;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic test_reset_values();
		@(negedge clock);
		check_flag("reset done_req", 1'b0, done_req);
		check_flag("reset resp_ack", 1'b0, resp_ack);
		check_word("reset done_word", '0, done_word);
		check_stats("reset done_stats", '0, done_stats);
	endtask

	task automatic test_single_job();
		cu_return_t      word;
		response_stats_t stats;
		send_job("single job", JOB_MIXED, 1'b0, word, stats);
		receive_report("single job", word, stats, 0, 1'b0);
	endtask

	task automatic test_held_ack();
		cu_return_t      word_a;
		response_stats_t stats_a;
		cu_return_t      word_b;
		response_stats_t stats_b;
		int              hold;
		hold = 5 + int'((lcg_next() >> 16) % 16);
		send_job("held ack A", JOB_HOLD_A, 1'b0, word_a, stats_a);
		receive_report("held ack A", word_a, stats_a, hold, 1'b1);
		// Second job finishes while ack is still high
		send_job("held ack B", JOB_HOLD_B, 1'b0, word_b, stats_b);
		repeat (QUIET_CYCLES / 2) begin
			@(negedge clock);
			check_flag("held ack B early", 1'b0, done_req);
		end
		@(posedge clock);
		done_ack <= 1'b0;
		receive_report("held ack B", word_b, stats_b, 0, 1'b0);
	endtask

	task automatic test_back_to_back();
		cu_return_t      word_a;
		response_stats_t stats_a;
		cu_return_t      word_b;
		response_stats_t stats_b;
		// B stalls in the handshake until soft reset clears A
		send_job("pair A", JOB_PAIR_A, 1'b0, word_a, stats_a);
		send_job("pair B", JOB_PAIR_B, 1'b0, word_b, stats_b);
		receive_report("pair A", word_a, stats_a, 0, 1'b0);
		receive_report("pair B", word_b, stats_b, 0, 1'b0);
	endtask

	task automatic test_disabled();
		cu_return_t      word;
		response_stats_t stats;
		@(posedge clock);
		enabled_in <= 1'b0;
		send_job("disabled", JOB_DISABLED, 1'b0, word, stats);
		repeat (QUIET_CYCLES) begin
			@(negedge clock);
			check_flag("disabled quiet", 1'b0, done_req);
		end
		@(posedge clock);
		enabled_in <= 1'b1;
		receive_report("disabled", word, stats, 0, 1'b0);
	endtask

	task automatic test_all_errors();
		cu_return_t      word;
		response_stats_t stats;
		send_job("all errors", JOB_ERRORS, 1'b1, word, stats);
		receive_report("all errors", word, stats, 0, 1'b0);
	endtask

	////////////////////////////////////////////////////////////
	// Sequence and watchdog
	////////////////////////////////////////////////////////////

	initial begin
		lcg_state  = 32'h07ec_5939;
		rstn       = 1'b0;
		enabled_in = 1'b1;
		job_size   = '0;
		resp_req   = 1'b0;
		resp       = '0;
		done_ack   = 1'b0;
		repeat (3) @(posedge clock);
		rstn <= 1'b1;
		test_reset_values();
		test_single_job();
		test_held_ack();
		test_back_to_back();
		test_disabled();
		test_all_errors();
		$display("Simulation completed successfully");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		report_failure("Watchdog expired before all tests finished");
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+common
common/afu_pkg.sv
rtl/done_control/soft_reset_sequencer.sv
rtl/done_control/done_control.sv
rtl/compute_unit.sv
rtl/response_stats.sv
rtl/afu_done_top.sv
verification/afu_done_tb.sv

// ==== Makefile ====
# Verilator build, run and lint for the job-completion path

VERILATOR  ?= verilator
TOP        := afu_done_tb
RTL_TOP    := afu_done_top
FILELIST   := src.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing -j 0 --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Non-zero exit status on $fatal fails the target
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
